// ==== eth_pkg.sv ====
package eth_pkg;

   // Buffer sizing
   localparam int buffer_w = 11;             // 2048 bytes per frame buffer

   // MII framing
   localparam int preamble_nibbles = 15;     // 0x5 nibbles ahead of the SFD nibble
   localparam logic [3:0] sfd_nibble = 4'hd; // Upper nibble of SFD byte 0xD5

   // IEEE 802.3 CRC-32
   localparam logic [31:0] crc_poly = 32'hedb88320;    // Reflected form
   // Good-frame residue in normal bit order.
   // A right-shifting register holds its bit reverse
   localparam logic [31:0] crc_residue = 32'hc704dd7b;

   // One byte write into a frame buffer
   typedef struct packed {
      logic [buffer_w-1:0] addr;  // Byte address
      logic [7:0]          data;  // Byte value
   } buf_wr_t;

   // Host send command, sampled with the send strobe
   typedef struct packed {
      logic [buffer_w-1:0] nbytes;  // Payload length in bytes
      logic                crc_en;  // Append FCS after payload
   } tx_cmd_t;

   // Receive result, valid with the done strobe
   typedef struct packed {
      logic [buffer_w-1:0] nbytes;   // Whole bytes after SFD, FCS included
      logic                crc_err;  // Residue mismatch
   } rx_status_t;

endpackage

// ==== eth_crc32.sv ====
`timescale 1ns/1ps

module eth_crc32 (
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        init_i,    // Preset to all ones
   input  logic        en_i,      // Absorb one nibble
   input  logic [3:0]  nibble_i,
   output logic [31:0] crc_o      // Running value, not inverted
);

   logic [31:0] crc_next;

   // Four serial steps, bit 0 of the nibble enters first
   always_comb begin
      crc_next = crc_o;
      for (int i = 0; i < 4; i++) begin
         if (crc_next[0] ^ nibble_i[i]) begin
            crc_next = (crc_next >> 1) ^ eth_pkg::crc_poly;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         crc_o <= '1;
      end else if (init_i) begin
         crc_o <= '1;          // Start of a new frame wins over en_i
      end else if (en_i) begin
         crc_o <= crc_next;
      end
   end

endmodule

// ==== eth_frame_buffer.sv ====
`timescale 1ns/1ps

module eth_frame_buffer (
   input  logic                         clk_i,
   input  logic                         wr_en_i,    // One byte per strobe
   input  eth_pkg::buf_wr_t             wr_i,
   input  logic [eth_pkg::buffer_w-1:0] rd_addr_i,
   output logic [7:0]                   rd_data_o   // One cycle after rd_addr_i
);

   // Byte storage, one full frame
   logic [7:0] mem [2**eth_pkg::buffer_w];

   // Write port
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // Read port always enabled
   // Same-address write in the same cycle returns the old byte
   always_ff @(posedge clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

   // Writer must present a clean address and byte
   a_wr_known: assert property (
      @(posedge clk_i) wr_en_i |-> !$isunknown(wr_i)
   ) else $error("frame buffer write with unknown address or data");

endmodule

// ==== eth_tx.sv ====
`timescale 1ns/1ps

module eth_tx (
   input  logic                         clk_i,
   input  logic                         reset_i,
   // Host command
   input  logic                         send_i,      // Ignored while busy
   input  eth_pkg::tx_cmd_t             cmd_i,
   output logic                         ready_o,
   // Transmit buffer read side
   output logic [eth_pkg::buffer_w-1:0] rd_addr_o,
   input  logic [7:0]                   rd_data_i,   // Byte for last cycle's address
   // MII transmit
   output logic                         mii_tx_en_o,
   output logic [3:0]                   mii_txd_o
);

   typedef enum logic [2:0] {
      st_idle,
      st_preamble,  // 15 x 0x5 then SFD nibble
      st_data_lo,
      st_data_hi,
      st_fcs        // Inverted CRC, 8 nibbles
   } tx_state_t;

   tx_state_t                    state_q;
   eth_pkg::tx_cmd_t             cmd_q;     // Latched at send
   logic [3:0]                   nib_cnt;   // Preamble and FCS position
   logic [eth_pkg::buffer_w-1:0] byte_cnt;  // Doubles as buffer read address
   logic                         start;
   logic                         crc_en;
   logic [31:0]                  crc;

   assign ready_o     = (state_q == st_idle);
   assign mii_tx_en_o = (state_q != st_idle);
   assign start       = send_i && ready_o;   // Accepted send
   assign rd_addr_o   = byte_cnt;
   assign crc_en      = (state_q == st_data_lo) || (state_q == st_data_hi);

   // Sequencer
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= st_idle;
         nib_cnt  <= '0;
         byte_cnt <= '0;
      end else begin
         case (state_q)
            st_idle: begin
               if (start) begin
                  state_q  <= st_preamble;
                  nib_cnt  <= '0;
                  byte_cnt <= '0;     // Byte 0 read issued during SFD
               end
            end
            st_preamble: begin
               nib_cnt <= nib_cnt + 4'd1;
               if (nib_cnt == 4'(eth_pkg::preamble_nibbles)) begin
                  nib_cnt <= '0;
                  if (cmd_q.nbytes != '0) begin
                     state_q <= st_data_lo;
                  end else if (cmd_q.crc_en) begin
                     state_q <= st_fcs;  // Empty payload
                  end else begin
                     state_q <= st_idle;
                  end
               end
            end
            st_data_lo: begin
               // Next address out now, its byte lands at the next low nibble
               byte_cnt <= byte_cnt + 1'b1;
               state_q  <= st_data_hi;
            end
            st_data_hi: begin
               if (byte_cnt == cmd_q.nbytes) begin  // Last byte done
                  state_q <= cmd_q.crc_en ? st_fcs : st_idle;
               end else begin
                  state_q <= st_data_lo;
               end
            end
            st_fcs: begin
               nib_cnt <= nib_cnt + 4'd1;
               if (nib_cnt == 4'd7) begin
                  state_q <= st_idle;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // Command held for the whole frame
   always_ff @(posedge clk_i) begin
      if (start) begin
         cmd_q <= cmd_i;
      end
   end

   // Nibble mux, low nibble first
   always_comb begin
      case (state_q)
         st_preamble: begin
            if (nib_cnt == 4'(eth_pkg::preamble_nibbles)) begin
               mii_txd_o = eth_pkg::sfd_nibble;
            end else begin
               mii_txd_o = 4'h5;
            end
         end
         st_data_lo: mii_txd_o = rd_data_i[3:0];
         st_data_hi: mii_txd_o = rd_data_i[7:4];     // Address unchanged last cycle
         st_fcs:     mii_txd_o = ~crc[4*nib_cnt[2:0] +: 4];  // LS nibble first
         default:    mii_txd_o = 4'h0;
      endcase
   end

   // CRC over payload nibbles only
   eth_crc32 crc_gen (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .init_i  (start),
      .en_i    (crc_en),
      .nibble_i(mii_txd_o),
      .crc_o   (crc)
   );

   // Reads stay inside the payload
   a_rd_in_frame: assert property (
      @(posedge clk_i) disable iff (reset_i)
         (state_q == st_data_lo) |-> (byte_cnt < cmd_q.nbytes)
   ) else $error("tx buffer read past end of payload");

   // Buffer contents reach the wire clean
   a_txd_known: assert property (
      @(posedge clk_i) disable iff (reset_i) mii_tx_en_o |-> !$isunknown(mii_txd_o)
   ) else $error("unknown MII nibble while tx enabled");

endmodule

// ==== eth_rx.sv ====
`timescale 1ns/1ps

module eth_rx (
   input  logic                clk_i,
   input  logic                reset_i,
   // MII receive
   input  logic                mii_rx_dv_i,
   input  logic [3:0]          mii_rxd_i,
   // Receive buffer write side
   output logic                wr_en_o,
   output eth_pkg::buf_wr_t    wr_o,
   // Frame result
   output logic                done_o,     // One cycle pulse
   output eth_pkg::rx_status_t status_o
);

   typedef enum logic {
      st_hunt,  // Waiting for SFD nibble
      st_data   // Pairing nibbles into bytes
   } rx_state_t;

   rx_state_t                    state_q;
   logic                         have_lo;    // Low nibble of current byte held
   logic [3:0]                   lo_q;
   logic [eth_pkg::buffer_w-1:0] byte_cnt;   // Next write address
   logic                         sfd_seen;
   logic                         byte_done;
   logic                         frame_end;
   logic [31:0]                  crc;
   logic [31:0]                  crc_rev;    // Normal bit order

   assign sfd_seen  = (state_q == st_hunt) && mii_rx_dv_i
                      && (mii_rxd_i == eth_pkg::sfd_nibble);
   assign byte_done = (state_q == st_data) && mii_rx_dv_i && have_lo;
   assign frame_end = (state_q == st_data) && !mii_rx_dv_i;  // First dv low
   assign crc_rev   = {<<{crc}};

   // Control
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q  <= st_hunt;
         have_lo  <= 1'b0;
         byte_cnt <= '0;
         wr_en_o  <= 1'b0;
         done_o   <= 1'b0;
      end else begin
         wr_en_o <= byte_done;   // Byte write one cycle after high nibble
         done_o  <= frame_end;
         case (state_q)
            st_hunt: begin
               if (sfd_seen) begin
                  state_q  <= st_data;
                  have_lo  <= 1'b0;
                  byte_cnt <= '0;   // Old frame overwritten from address 0
               end
            end
            st_data: begin
               if (mii_rx_dv_i) begin
                  have_lo <= !have_lo;
                  if (byte_done) begin
                     byte_cnt <= byte_cnt + 1'b1;
                  end
               end else begin
                  state_q <= st_hunt;  // Odd trailing nibble dropped
               end
            end
            default: state_q <= st_hunt;
         endcase
      end
   end

   // Byte assembly and status capture
   always_ff @(posedge clk_i) begin
      if ((state_q == st_data) && mii_rx_dv_i && !have_lo) begin
         lo_q <= mii_rxd_i;
      end
      if (byte_done) begin
         wr_o.addr <= byte_cnt;
         wr_o.data <= {mii_rxd_i, lo_q};
      end
      if (frame_end) begin
         status_o.nbytes  <= byte_cnt;              // FCS bytes counted too
         status_o.crc_err <= (crc_rev != eth_pkg::crc_residue);
      end
   end

   // Every data nibble, FCS included, goes through the CRC
   eth_crc32 crc_chk (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .init_i  (sfd_seen),
      .en_i    ((state_q == st_data) && mii_rx_dv_i),
      .nibble_i(mii_rxd_i),
      .crc_o   (crc)
   );

   a_done_pulse: assert property (
      @(posedge clk_i) disable iff (reset_i) done_o |=> !done_o
   ) else $error("rx done longer than one cycle");

   // Frame length stays below buffer size
   a_no_wrap: assert property (
      @(posedge clk_i) disable iff (reset_i) byte_done |-> (byte_cnt != '1)
   ) else $error("rx write address wrapped within a frame");

endmodule

// ==== eth_core.sv ====
`timescale 1ns/1ps

module eth_core (
   input  logic                         clk_i,
   input  logic                         reset_i,
   // Host transmit side
   input  logic                         tx_wr_en_i,
   input  eth_pkg::buf_wr_t             tx_wr_i,
   input  logic                         tx_send_i,
   input  eth_pkg::tx_cmd_t             tx_cmd_i,
   output logic                         tx_ready_o,
   // MII transmit
   output logic                         mii_tx_en_o,
   output logic [3:0]                   mii_txd_o,
   // MII receive
   input  logic                         mii_rx_dv_i,
   input  logic [3:0]                   mii_rxd_i,
   // Host receive side
   output logic                         rx_done_o,
   output eth_pkg::rx_status_t          rx_status_o,
   input  logic [eth_pkg::buffer_w-1:0] rx_rd_addr_i,
   output logic [7:0]                   rx_rd_data_o
);

   logic [eth_pkg::buffer_w-1:0] tx_rd_addr;  // tx to its buffer
   logic [7:0]                   tx_rd_data;
   logic                         rx_wr_en;    // rx into its buffer
   eth_pkg::buf_wr_t             rx_wr;

   // Host fills, transmitter drains
   eth_frame_buffer tx_buffer (
      .clk_i    (clk_i),
      .wr_en_i  (tx_wr_en_i),
      .wr_i     (tx_wr_i),
      .rd_addr_i(tx_rd_addr),
      .rd_data_o(tx_rd_data)
   );

   eth_tx tx (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .send_i     (tx_send_i),
      .cmd_i      (tx_cmd_i),
      .ready_o    (tx_ready_o),
      .rd_addr_o  (tx_rd_addr),
      .rd_data_i  (tx_rd_data),
      .mii_tx_en_o(mii_tx_en_o),
      .mii_txd_o  (mii_txd_o)
   );

   eth_rx rx (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .mii_rx_dv_i(mii_rx_dv_i),
      .mii_rxd_i  (mii_rxd_i),
      .wr_en_o    (rx_wr_en),
      .wr_o       (rx_wr),
      .done_o     (rx_done_o),
      .status_o   (rx_status_o)
   );

   // Receiver fills, host reads back
   eth_frame_buffer rx_buffer (
      .clk_i    (clk_i),
      .wr_en_i  (rx_wr_en),
      .wr_i     (rx_wr),
      .rd_addr_i(rx_rd_addr_i),
      .rd_data_o(rx_rd_data_o)
   );

endmodule

// ==== tb_eth_core.sv ====
`timescale 1ns/1ps

module tb_eth_core;

   localparam int n_frames = 9;   // 4 with FCS, 2 without, 2 corrupted, 1 busy send

   typedef logic [eth_pkg::buffer_w-1:0] addr_t;

   // DUT ports
   logic                clk_i = 1'b0;
   logic                reset_i = 1'b1;
   logic                tx_wr_en_i;
   eth_pkg::buf_wr_t    tx_wr_i;
   logic                tx_send_i;
   eth_pkg::tx_cmd_t    tx_cmd_i;
   logic                tx_ready_o;
   logic                mii_tx_en_o;
   logic [3:0]          mii_txd_o;
   logic                mii_rx_dv_i = 1'b0;   // Loopback, set on falling edge
   logic [3:0]          mii_rxd_i = 4'h0;
   logic                rx_done_o;
   eth_pkg::rx_status_t rx_status_o;
   addr_t               rx_rd_addr_i;
   logic [7:0]          rx_rd_data_o;

   // Stimulus and scoreboard
   logic [15:0]         lfsr = 16'd30771;
   int                  n_list [n_frames];     // Payload lengths, drawn up front
   logic [7:0]          payload [64];
   logic [7:0]          rx_exp [64];           // Payload, FCS bytes, corruption applied
   logic [3:0]          exp_q [$];             // Nibbles still due on the wire
   logic [3:0]          exp_nib = 4'h0;        // Due in the current cycle
   logic                exp_valid = 1'b0;
   int                  exp_left = 0;
   eth_pkg::rx_status_t exp_status = '0;
   logic                corrupt_on = 1'b0;
   int                  corrupt_at = 0;        // Nibble index within the frame
   int                  nib_idx = 0;
   int                  done_cnt = 0;
   int                  frames_done = 0;
   int                  cycle_cnt = 0;
   int                  cycle_limit = 0;

   eth_core dut_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .tx_wr_en_i  (tx_wr_en_i),
      .tx_wr_i     (tx_wr_i),
      .tx_send_i   (tx_send_i),
      .tx_cmd_i    (tx_cmd_i),
      .tx_ready_o  (tx_ready_o),
      .mii_tx_en_o (mii_tx_en_o),
      .mii_txd_o   (mii_txd_o),
      .mii_rx_dv_i (mii_rx_dv_i),
      .mii_rxd_i   (mii_rxd_i),
      .rx_done_o   (rx_done_o),
      .rx_status_o (rx_status_o),
      .rx_rd_addr_i(rx_rd_addr_i),
      .rx_rd_data_o(rx_rd_data_o)
   );

   always #2 clk_i = ~clk_i;   // 4 ns period

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic value_error(input string msg);
      abort_run($sformatf("ERR %0t %s", $time, msg));
   endtask

   // Fibonacci LFSR, taps 16 14 13 11
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      return fb;
   endfunction

   function automatic int rand_bits(input int width);
      int v;
      v = 0;
      for (int i = 0; i < width; i++) begin
         v = (v << 1) | int'(lfsr_bit());   // One step per bit
      end
      return v;
   endfunction

   // Bit-serial reflected CRC-32 over bytes, LSB first, result inverted
   function automatic logic [31:0] ref_fcs(input int n);
      logic [31:0] c;
      c = 32'hffffffff;
      for (int i = 0; i < n; i++) begin
         for (int b = 0; b < 8; b++) begin
            if (c[0] ^ payload[i][b]) begin
               c = (c >> 1) ^ 32'hedb88320;
            end else begin
               c = c >> 1;
            end
         end
      end
      return ~c;
   endfunction

   // Loopback with an optional inverted nibble
   always @(negedge clk_i) begin
      logic [3:0] flip;
      flip = (corrupt_on && mii_tx_en_o && nib_idx == corrupt_at) ? 4'hf : 4'h0;
      mii_rx_dv_i <= mii_tx_en_o;
      mii_rxd_i   <= mii_txd_o ^ flip;
      if (mii_tx_en_o) begin
         nib_idx <= nib_idx + 1;
      end else begin
         nib_idx <= 0;   // Next frame counts from preamble
      end
   end

   // Scoreboard head for this cycle, sampled mid-cycle
   always @(negedge clk_i) begin
      if (mii_tx_en_o && exp_q.size() != 0) begin
         exp_nib   = exp_q.pop_front();
         exp_valid = 1'b1;
      end else begin
         exp_valid = 1'b0;   // Nothing due, any tx_en is an error
      end
      exp_left = exp_q.size();
      if (rx_done_o) begin
         done_cnt = done_cnt + 1;
      end
   end

   a_tx_nibble: assert property (@(posedge clk_i) disable iff (reset_i)
      mii_tx_en_o |-> (exp_valid && mii_txd_o == exp_nib))
      else value_error($sformatf("tx nibble wrong or frame too long, expected 0x%h", exp_nib));

   a_tx_length: assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(mii_tx_en_o) |-> (exp_left == 0))
      else value_error($sformatf("tx frame ended with %0d nibbles missing", exp_left));

   a_tx_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      mii_tx_en_o |-> !tx_ready_o)
      else value_error("tx_ready_o high during a frame");

   a_rx_status: assert property (@(posedge clk_i) disable iff (reset_i)
      rx_done_o |-> (rx_status_o == exp_status))
      else value_error($sformatf("rx status nbytes %0d crc_err %0b, expected %0d %0b",
                                 rx_status_o.nbytes, rx_status_o.crc_err,
                                 exp_status.nbytes, exp_status.crc_err));

   // Watchdog
   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         abort_run($sformatf("Timeout after %0d cycles, a frame never completed", cycle_cnt));
      end
   end

   task automatic load_payload(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk_i);
         tx_wr_en_i   = 1'b1;
         tx_wr_i.addr = addr_t'(i);
         tx_wr_i.data = payload[i];
      end
      @(negedge clk_i);
      tx_wr_en_i = 1'b0;
   endtask

   task automatic send_cmd(input int n, input logic with_fcs);
      while (!tx_ready_o) begin
         @(negedge clk_i);
      end
      tx_cmd_i.nbytes = addr_t'(n);
      tx_cmd_i.crc_en = with_fcs;
      tx_send_i       = 1'b1;
      @(negedge clk_i);
      tx_send_i = 1'b0;
   endtask

   task automatic read_back(input int nb);
      for (int i = 0; i < nb; i++) begin
         rx_rd_addr_i = addr_t'(i);
         @(negedge clk_i);   // One cycle read latency
         assert (rx_rd_data_o === rx_exp[i])
            else value_error($sformatf("rx buffer byte %0d is 0x%h, expected 0x%h",
                                       i, rx_rd_data_o, rx_exp[i]));
      end
   endtask

   task automatic run_frame(input int n, input logic with_fcs, input logic corrupt,
                            input logic busy);
      logic [31:0] fcs;
      int          nb;
      int          k;
      for (int i = 0; i < n; i++) begin
         payload[i] = 8'(rand_bits(8));
      end
      fcs = ref_fcs(n);
      repeat (15) exp_q.push_back(4'h5);
      exp_q.push_back(4'hd);                      // SFD
      for (int i = 0; i < n; i++) begin
         exp_q.push_back(payload[i][3:0]);        // Low nibble first
         exp_q.push_back(payload[i][7:4]);
         rx_exp[i] = payload[i];
      end
      for (int j = 0; j < 8 && with_fcs; j++) begin
         exp_q.push_back(fcs[4*j +: 4]);
      end
      for (int j = 0; j < 4; j++) begin
         rx_exp[n+j] = fcs[8*j +: 8];
      end
      nb = with_fcs ? n + 4 : n;
      corrupt_on = 1'b0;
      if (corrupt) begin
         k          = rand_bits(7) % (2 * n);     // Data nibble only
         corrupt_at = 16 + k;
         rx_exp[k/2] = rx_exp[k/2] ^ ((k % 2) ? 8'hf0 : 8'h0f);
         corrupt_on = 1'b1;
      end
      exp_status.nbytes  = addr_t'(nb);
      exp_status.crc_err = !with_fcs || corrupt;  // Bare payload never leaves the residue
      load_payload(n);
      send_cmd(n, with_fcs);
      if (busy) begin
         repeat (6) @(negedge clk_i);
         tx_cmd_i.nbytes = addr_t'(n + 3);        // Would change the frame if taken
         tx_cmd_i.crc_en = !with_fcs;
         tx_send_i       = 1'b1;
         @(negedge clk_i);
         tx_send_i = 1'b0;
      end
      while (!rx_done_o) begin
         @(negedge clk_i);
      end
      frames_done = frames_done + 1;
      read_back(nb);
      assert (done_cnt == frames_done)
         else value_error($sformatf("rx done count %0d after %0d frames", done_cnt, frames_done));
   endtask

   initial begin
      int limit;
      tx_wr_en_i   = 1'b0;
      tx_wr_i      = '0;
      tx_send_i    = 1'b0;
      tx_cmd_i     = '0;
      rx_rd_addr_i = '0;
      for (int f = 0; f < n_frames; f++) begin
         n_list[f] = 4 + rand_bits(6) % 37;      // 4 to 40 bytes
      end
      // Wire time plus host buffer writes and readback
      limit = 200;
      for (int f = 0; f < n_frames; f++) begin
         limit = limit + (2 * n_list[f] + 40) + (2 * n_list[f] + 8);
      end
      cycle_limit = limit;
      repeat (4) @(negedge clk_i);
      reset_i = 1'b0;
      assert (!mii_tx_en_o && !rx_done_o && tx_ready_o)
         else value_error("outputs not idle after reset");
      for (int f = 0; f < 4; f++) begin
         run_frame(n_list[f], 1'b1, 1'b0, 1'b0);
      end
      for (int f = 4; f < 6; f++) begin
         run_frame(n_list[f], 1'b0, 1'b0, 1'b0);
      end
      for (int f = 6; f < 8; f++) begin
         run_frame(n_list[f], 1'b1, 1'b1, 1'b0);
      end
      run_frame(n_list[8], 1'b1, 1'b0, 1'b1);
      repeat (80) @(negedge clk_i);                // Room for a stray frame to show up
      assert (done_cnt == n_frames)
         else value_error($sformatf("%0d rx frames seen, expected %0d", done_cnt, n_frames));
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// ==== compile.f ====
eth_pkg.sv
eth_crc32.sv
eth_frame_buffer.sv
eth_tx.sv
eth_rx.sv
eth_core.sv
tb_eth_core.sv

// ==== Makefile ====
# Verilator flow for the Ethernet MAC datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_eth_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit code
run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
